// ==== filelist.f ====
+incdir+verification
design/sj_pkg.sv
design/sj_palette_out.sv
design/sj_priority_mixer.sv
design/sj_apb_regs.sv
design/sj_video_top.sv
verification/tb_sj_video_top.sv

// ==== Makefile ====
# Verilator build and run of the SJ video back end testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_sj_video_top
FILELIST  ?= filelist.f
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== verification/tb_apb_bfm.svh ====
// Included inside the testbench module; expects clk, APB signals, exp_wait, exp_err, errors
`ifndef TB_APB_BFM_SVH
`define TB_APB_BFM_SVH

logic [31:0] lfsr_state = 32'hdc17f5c5;

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		r = {r[30:0], lfsr_state[0]};
		if (lfsr_state[0])
			lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
		else
			lfsr_state = lfsr_state >> 1;
	end
	return r;
endfunction

task automatic apb_transfer(input logic [9:0] addr, input logic wr, input logic [7:0] data,
	input logic ram_wait, input logic err, output logic [7:0] rdata);
	logic done;
	int   n;
	done  = 1'b0;
	n     = 0;
	rdata = 8'h00;
	@(negedge clk);
	exp_wait = ram_wait;	// Read by the protocol assertions
	exp_err  = err;
	paddr    = addr;
	pwrite   = wr;
	pwdata   = data;
	psel     = 1'b1;
	penable  = 1'b0;
	@(negedge clk);
	penable = 1'b1;
	while (!done && n < 4) begin
		#1;
		done  = pready;	// Stable until the next rising edge
		rdata = prdata;
		@(posedge clk);
		n++;
		if (!done)
			@(negedge clk);
	end
	if (!done) begin
		$display("%s: transfer to %h never completed", cur_test, addr);
		errors++;
	end
	@(negedge clk);
	psel    = 1'b0;
	penable = 1'b0;
	pwrite  = 1'b0;
endtask

`endif

// ==== verification/tb_sj_video_top.sv ====
// RGB is checked only once the table and palette entries it uses have been written
`default_nettype none

module tb_sj_video_top;

	import sj_pkg::*;

	localparam int N_PIX       = 300;
	localparam int T1_CYC      = 120;	// 30 transfers
	localparam int T2_CYC      = 40;
	localparam int T3_CYC      = 130;
	localparam int T4_CYC      = 1540 + 2 * (40 + 2 * N_PIX + 8);
	localparam int T5_CYC      = 120 + 2 * N_PIX;
	localparam int CYCLE_LIMIT = 2 * (8 + T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC);

	logic clk = 1'b0;
	logic rst_n;
	logic [9:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] pwdata;
	logic [7:0] prdata;
	logic pready;
	logic pslverr;
	logic pix_ce;
	logic blank;
	sj_layer_pix_t layer_pix;
	sj_inputs_t inputs;
	sj_rgb_t rgb;

	// ========================================================================
	// Reference model and expected pixel pipeline
	// ========================================================================
	logic [3:0] prio_m [256];
	logic prio_known [256];
	logic [8:0] pal_m [64];
	logic pal_known [64];
	logic latch_m;
	sj_colour_codes_t codes_m;
	logic [4:0] pc_m;
	logic [9:0] exp_s0;	// Valid bit over rgb
	logic [9:0] exp_s1;
	logic [9:0] exp_s2;
	logic exp_valid;
	sj_rgb_t exp_rgb;
	logic exp_wait;
	logic exp_err;
	logic wait_seen;
	string cur_test = "reset";
	int errors = 0;
	int err_start = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;

	`include "tb_apb_bfm.svh"

	sj_video_top #(.APB_ADDR_W(10)) i_dut (
		.V_BLANK(clk), .EXROM2(rst_n), .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
		.pwrite_i(pwrite), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
		.pslverr_o(pslverr), .pix_ce_i(pix_ce), .layer_pix_i(layer_pix), .blank_i(blank),
		.inputs_i(inputs), .rgb_o(rgb)
	);

	always #10 clk = ~clk;

	function automatic void model_write(input logic [9:0] a, input logic [7:0] d);
		if (a[9:8] == 2'b00) begin
			prio_m[a[7:0]]     = d[3:0];
			prio_known[a[7:0]] = 1'b1;
		end else if (a[9:7] == 3'b010) begin
			if (a[0]) begin
				latch_m = d[0];
			end else begin
				pal_m[a[6:1]]     = {latch_m, d};
				pal_known[a[6:1]] = 1'b1;
			end
		end else if (a == ADDR_MD12) begin
			codes_m.md1 = d[2:0];
			codes_m.md2 = d[6:4];
		end else if (a == ADDR_MD3) begin
			codes_m.md3 = d[2:0];
			codes_m.md0 = d[5:4];
		end else if (a == ADDR_PRIORITY) begin
			pc_m = d[4:0];
		end
	endfunction

	function automatic logic [9:0] expect_pixel(input sj_layer_pix_t p, input logic blk);
		logic [7:0] idx;
		logic [3:0] entry;
		logic [1:0] lay;
		logic [5:0] pidx;
		logic [8:0] word;
		if (blk)
			return {1'b1, 9'h000};
		idx = {pc_m[3:0], |p.sn3, |p.sn2, |p.sn1, |p.ob[2:0]};
		if (!prio_known[idx])
			return 10'h000;	// Unknown entry, don't care
		entry = prio_m[idx];
		lay   = pc_m[4] ? entry[3:2] : entry[1:0];
		case (lay)
			2'd0: pidx = {codes_m.md0, p.ob};
			2'd1: pidx = {codes_m.md1, p.sn1};
			2'd2: pidx = {codes_m.md2, p.sn2};
			default: pidx = {codes_m.md3, p.sn3};
		endcase
		if (!pal_known[pidx])
			return 10'h000;
		word = pal_m[pidx];
		return {1'b1, ~word[8:6], ~word[5:3], ~word[2:0]};
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_s0    <= '0;
			exp_s1    <= '0;
			exp_s2    <= '0;
			exp_valid <= 1'b0;
			exp_rgb   <= '0;
			wait_seen <= 1'b0;
		end else begin
			wait_seen <= psel && penable && !pready;
			if (pix_ce) begin
				exp_s0    <= expect_pixel(layer_pix, blank);
				exp_s1    <= exp_s0;
				exp_s2    <= exp_s1;
				exp_valid <= exp_s2[9];
				exp_rgb   <= exp_s2[8:0];	// Shows after the fourth enabled cycle
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: no result after %0d cycles", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// ========================================================================
	// Checking assertions
	// ========================================================================
	a_first_access: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && penable && !wait_seen) |-> (pready == !exp_wait)) else begin
		$display("FAILED %s pready expected %0b actual %0b", cur_test,
			!$sampled(exp_wait), $sampled(pready));
		errors++;
	end
	a_one_wait: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && penable && wait_seen) |-> pready) else begin
		$display("%s: transfer waited more than one cycle", cur_test);
		errors++;
	end
	a_slverr: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && penable && pready) |-> (pslverr == exp_err)) else begin
		$display("FAILED %s pslverr expected %0b actual %0b", cur_test,
			$sampled(exp_err), $sampled(pslverr));
		errors++;
	end
	a_rgb: assert property (@(negedge clk) disable iff (!rst_n)
		exp_valid |-> (rgb == exp_rgb)) else begin
		$display("FAILED %s rgb expected %h actual %h", cur_test, $sampled(exp_rgb),
			$sampled(rgb));
		errors++;
	end
	a_reset_black: assert property (@(negedge clk) !rst_n |-> (rgb == 9'h000)) else begin
		$display("%s: rgb not black during reset", cur_test);
		errors++;
	end

	// ========================================================================
	// Stimulus helpers
	// ========================================================================
	task automatic check_value(input string what, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp) else begin
			$display("FAILED %s/%s expected %h actual %h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic reg_write(input logic [9:0] a, input logic [7:0] d);
		logic [7:0] unused;
		apb_transfer(a, 1'b1, d, 1'b0, 1'b0, unused);
		model_write(a, d);
	endtask

	task automatic reg_read(input logic [9:0] a, input logic ram, output logic [7:0] d);
		apb_transfer(a, 1'b0, 8'h00, ram, 1'b0, d);
	endtask

	task automatic pal_fill(input logic [5:0] e, input logic [8:0] w);
		reg_write(ADDR_PAL_BASE + {3'b000, e, 1'b1}, {7'b0000000, w[8]});	// Latch first
		reg_write(ADDR_PAL_BASE + {3'b000, e, 1'b0}, w[7:0]);
	endtask

	task automatic pal_check(input logic [5:0] e);
		logic [7:0] rd;
		reg_read(ADDR_PAL_BASE + {3'b000, e, 1'b0}, 1'b1, rd);
		check_value("pal_lo", pal_m[e][7:0], rd);
		reg_read(ADDR_PAL_BASE + {3'b000, e, 1'b1}, 1'b1, rd);
		check_value("pal_hi", {7'b0000000, pal_m[e][8]}, rd);
	endtask

	task automatic run_pixels(input int n, input logic use_blank);
		int sent;
		sent = 0;
		while (sent < n) begin
			@(negedge clk);
			pix_ce    = (rand_bits(2) != 0);	// Gaps hold the pipeline
			layer_pix = sj_layer_pix_t'(13'(rand_bits(13)));
			blank     = use_blank && (rand_bits(3) == 0);
			if (pix_ce)
				sent++;
		end
		repeat (4) begin
			@(negedge clk);
			pix_ce = 1'b1;
			blank  = 1'b1;
		end
		@(negedge clk);
		pix_ce = 1'b0;
		blank  = 1'b0;
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		err_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == err_start) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", cur_test, errors - err_start);
		end
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================
	initial begin
		logic [7:0] d;
		logic [7:0] rd;
		rst_n = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		pix_ce = 1'b0;
		layer_pix = '0;
		blank = 1'b0;
		inputs = '0;
		exp_wait = 1'b0;
		exp_err = 1'b0;
		latch_m = 1'b0;
		codes_m = '0;
		pc_m = '0;
		for (int i = 0; i < 256; i++)
			prio_known[i] = 1'b0;
		for (int i = 0; i < 64; i++)
			pal_known[i] = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		begin_test("register_readback");
		for (int r = 0; r < 3; r++) begin
			d = 8'(rand_bits(8));
			reg_write(ADDR_MD12, d);
			reg_read(ADDR_MD12, 1'b0, rd);
			check_value("md12", {1'b0, d[6:4], 1'b0, d[2:0]}, rd);
			d = 8'(rand_bits(8));
			reg_write(ADDR_MD3, d);
			reg_read(ADDR_MD3, 1'b0, rd);
			check_value("md3", {2'b00, d[5:4], 1'b0, d[2:0]}, rd);
			d = 8'(rand_bits(8));
			reg_write(ADDR_PRIORITY, d);
			reg_read(ADDR_PRIORITY, 1'b0, rd);
			check_value("priority", {3'b000, d[4:0]}, rd);
			inputs = sj_inputs_t'(19'(rand_bits(19)));
			reg_read(ADDR_IN0, 1'b0, rd);
			check_value("in0", {2'b10, inputs.shoot2, inputs.shoot, inputs.up, inputs.down,
				inputs.right, inputs.left}, rd);
			reg_read(ADDR_IN3, 1'b0, rd);
			check_value("in3", {inputs.start2p, inputs.start1p, inputs.coina, inputs.coinb,
				4'b0000}, rd);
			reg_read(ADDR_IN4, 1'b0, rd);
			check_value("in4", {3'b111, inputs.service, 4'b0000}, rd);
			reg_read(ADDR_DSWA, 1'b0, rd);
			check_value("dswa", ~inputs.dip1, rd);
		end
		end_test();

		begin_test("apb_protocol");
		reg_read(10'h010, 1'b1, rd);	// Table and palette reads wait once
		reg_read(10'h150, 1'b1, rd);
		reg_read(ADDR_MD3, 1'b0, rd);
		reg_write(ADDR_PRIORITY, 8'h00);
		apb_transfer(10'h203, 1'b0, 8'h00, 1'b0, 1'b1, rd);
		apb_transfer(10'h180, 1'b0, 8'h00, 1'b0, 1'b1, rd);
		apb_transfer(10'h3FF, 1'b0, 8'h00, 1'b0, 1'b1, rd);
		apb_transfer(ADDR_IN0, 1'b1, 8'hFF, 1'b0, 1'b1, rd);
		end_test();

		begin_test("palette_pairing");
		pal_fill(6'd0, 9'h1A5);
		pal_check(6'd0);
		pal_fill(6'd63, 9'h03C);
		pal_check(6'd63);
		reg_write(ADDR_PAL_BASE + 10'h00B, 8'h01);
		reg_write(ADDR_PAL_BASE + 10'h00A, 8'h11);	// Latch carries into this entry
		reg_write(ADDR_PAL_BASE + 10'h00C, 8'h22);
		pal_check(6'd5);
		pal_check(6'd6);
		for (int r = 0; r < 3; r++) begin
			d = 8'(rand_bits(6));
			pal_fill(d[5:0], 9'(rand_bits(9)));
			pal_check(d[5:0]);
		end
		end_test();

		begin_test("priority_select");
		for (int i = 0; i < 256; i++)
			reg_write(ADDR_PRIO_BASE + 10'(i), 8'(rand_bits(4)));
		reg_read(ADDR_PRIO_BASE + 10'h05A, 1'b1, rd);
		check_value("prio_5a", {4'b0000, prio_m[8'h5A]}, rd);
		for (int i = 0; i < 64; i++)
			pal_fill(6'(i), 9'(rand_bits(9)));
		for (int pass = 0; pass < 2; pass++) begin
			reg_write(ADDR_MD12, 8'(rand_bits(8)));
			reg_write(ADDR_MD3, 8'(rand_bits(8)));
			d = 8'(rand_bits(4));
			reg_write(ADDR_PRIORITY, {3'b000, pass[0], d[3:0]});	// Both table halves
			run_pixels(N_PIX, 1'b0);
		end
		end_test();

		begin_test("blank_and_reset");
		reg_write(ADDR_MD12, 8'h00);	// Every layer now indexes palette entry 0
		reg_write(ADDR_MD3, 8'h00);
		pal_fill(6'd0, 9'h000);
		@(negedge clk);
		pix_ce    = 1'b1;
		layer_pix = '0;
		blank     = 1'b0;
		repeat (4) @(negedge clk);
		pix_ce = 1'b0;
		check_value("rgb_before_reset", 8'hFF, rgb[7:0]);
		rst_n = 1'b0;
		latch_m = 1'b0;
		codes_m = '0;
		pc_m = '0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		check_value("rgb_after_reset", 8'h00, rgb[7:0]);
		check_value("red_msb_after_reset", 8'h00, {7'b0000000, rgb[8]});
		reg_read(ADDR_MD12, 1'b0, rd);
		check_value("md12_after_reset", 8'h00, rd);
		reg_read(ADDR_PRIORITY, 1'b0, rd);
		check_value("priority_after_reset", 8'h00, rd);
		run_pixels(N_PIX, 1'b1);
		end_test();

		repeat (2) @(negedge clk);
		$display("tests %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/sj_video_top.sv ====
// Pixel path has no back-pressure; pixels reach rgb_o four enabled cycles after sampling
`default_nettype none

module sj_video_top #(
	parameter int APB_ADDR_W = 10
) (
	input  wire logic                    V_BLANK,
	input  wire logic                    EXROM2,
	input  wire logic [APB_ADDR_W-1:0]   paddr_i,
	input  wire logic                    psel_i,
	input  wire logic                    penable_i,
	input  wire logic                    pwrite_i,
	input  wire logic [7:0]              pwdata_i,
	output logic [7:0]                   prdata_o,
	output logic                         pready_o,
	output logic                         pslverr_o,
	input  wire logic                    pix_ce_i,
	input  wire sj_pkg::sj_layer_pix_t   layer_pix_i,
	input  wire logic                    blank_i,
	input  wire sj_pkg::sj_inputs_t      inputs_i,
	output sj_pkg::sj_rgb_t              rgb_o
);

	import sj_pkg::*;

	sj_ram_req_t      ram_req;
	sj_colour_codes_t colour_codes;
	logic [4:0]       priority_ctrl;
	logic [3:0]       prio_rdata;
	logic [7:0]       pal_rdata;
	sj_pal_index_u    pal_index;
	logic             mix_blank;	// Blank aligned with pal_index

	// ========================================================================
	// Register decode, priority lookup, palette output
	// ========================================================================
	sj_apb_regs #(
		.APB_ADDR_W (APB_ADDR_W)
	) u_regs (
		.V_BLANK         (V_BLANK),
		.EXROM2          (EXROM2),
		.paddr_i         (paddr_i),
		.psel_i          (psel_i),
		.penable_i       (penable_i),
		.pwrite_i        (pwrite_i),
		.pwdata_i        (pwdata_i),
		.inputs_i        (inputs_i),
		.prio_rdata_i    (prio_rdata),
		.pal_rdata_i     (pal_rdata),
		.prdata_o        (prdata_o),
		.pready_o        (pready_o),
		.pslverr_o       (pslverr_o),
		.ram_req_o       (ram_req),
		.colour_codes_o  (colour_codes),
		.priority_ctrl_o (priority_ctrl)
	);

	sj_priority_mixer u_mixer (
		.V_BLANK         (V_BLANK),
		.EXROM2          (EXROM2),
		.pix_ce_i        (pix_ce_i),
		.layer_pix_i     (layer_pix_i),
		.blank_i         (blank_i),
		.colour_codes_i  (colour_codes),
		.priority_ctrl_i (priority_ctrl),
		.ram_req_i       (ram_req),
		.prio_rdata_o    (prio_rdata),
		.pal_index_o     (pal_index),
		.blank_o         (mix_blank)
	);

	sj_palette_out u_palette (
		.V_BLANK     (V_BLANK),
		.EXROM2      (EXROM2),
		.pix_ce_i    (pix_ce_i),
		.pal_index_i (pal_index),
		.blank_i     (mix_blank),
		.ram_req_i   (ram_req),
		.pal_rdata_o (pal_rdata),
		.rgb_o       (rgb_o)
	);

endmodule

`default_nettype wire

// ==== design/sj_apb_regs.sv ====
// APB_ADDR_W must be at least 10 and upper address bits must be zero; RAM reads take one wait state
`default_nettype none

module sj_apb_regs #(
	parameter int APB_ADDR_W = 10
) (
	input  wire logic                   V_BLANK,
	input  wire logic                   EXROM2,
	input  wire logic [APB_ADDR_W-1:0]  paddr_i,
	input  wire logic                   psel_i,
	input  wire logic                   penable_i,
	input  wire logic                   pwrite_i,
	input  wire logic [7:0]             pwdata_i,
	input  wire sj_pkg::sj_inputs_t     inputs_i,
	input  wire logic [3:0]             prio_rdata_i,
	input  wire logic [7:0]             pal_rdata_i,
	output logic [7:0]                  prdata_o,
	output logic                        pready_o,
	output logic                        pslverr_o,
	output sj_pkg::sj_ram_req_t         ram_req_o,
	output sj_pkg::sj_colour_codes_t    colour_codes_o,
	output logic [4:0]                  priority_ctrl_o
);

	import sj_pkg::*;

	logic [9:0] addr10;
	logic       hi_zero;
	logic       prio_hit;
	logic       pal_hit;
	logic       md12_hit;
	logic       md3_hit;
	logic       pri_hit;
	logic       in_hit;
	logic       mapped;
	logic       ram_rd;
	logic       acc_first;	// First access cycle of a transfer
	logic       wait_q;		// RAM read waiting for data
	logic [7:0] rd_data;

	// ========================================================================
	// Address decode
	// ========================================================================
	assign addr10  = paddr_i[9:0];
	assign hi_zero = ((paddr_i >> 10) == '0);

	always_comb begin
		prio_hit = hi_zero && (addr10[9:8] == ADDR_PRIO_BASE[9:8]);
		pal_hit  = hi_zero && (addr10[9:7] == ADDR_PAL_BASE[9:7]);
		md12_hit = hi_zero && (addr10 == ADDR_MD12);
		md3_hit  = hi_zero && (addr10 == ADDR_MD3);
		pri_hit  = hi_zero && (addr10 == ADDR_PRIORITY);
		in_hit   = hi_zero && ((addr10 == ADDR_IN0) || (addr10 == ADDR_IN3) ||
			(addr10 == ADDR_IN4) || (addr10 == ADDR_DSWA));
		mapped   = prio_hit || pal_hit || md12_hit || md3_hit || pri_hit || in_hit;
	end

	assign ram_rd    = !pwrite_i && (prio_hit || pal_hit);
	assign acc_first = psel_i && penable_i && !wait_q;

	assign pready_o  = psel_i && penable_i && (!ram_rd || wait_q);
	assign pslverr_o = pready_o && (!mapped || (pwrite_i && in_hit));

	// ========================================================================
	// RAM access routing
	// ========================================================================
	always_comb begin
		ram_req_o.we    = pwrite_i;
		ram_req_o.addr  = addr10[7:0];	// Palette byte offset sits in 6:0
		ram_req_o.wdata = pwdata_i;
		ram_req_o.sel   = RAM_NONE;
		if (acc_first && prio_hit)
			ram_req_o.sel = RAM_PRIO;
		else if (acc_first && pal_hit)
			ram_req_o.sel = RAM_PAL;
	end

	// ========================================================================
	// Control registers
	// ========================================================================
	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			colour_codes_o  <= '0;
			priority_ctrl_o <= '0;
			wait_q          <= 1'b0;
		end else begin
			wait_q <= acc_first && ram_rd;
			if (acc_first && pwrite_i) begin
				if (md12_hit) begin
					colour_codes_o.md1 <= pwdata_i[2:0];
					colour_codes_o.md2 <= pwdata_i[6:4];	// Bank bits dropped
				end
				if (md3_hit) begin
					colour_codes_o.md3 <= pwdata_i[2:0];
					colour_codes_o.md0 <= pwdata_i[5:4];
				end
				if (pri_hit)
					priority_ctrl_o <= pwdata_i[4:0];
			end
		end
	end

	// ========================================================================
	// Read data
	// ========================================================================
	always_comb begin
		rd_data = 8'h00;
		if (prio_hit)
			rd_data = {4'b0000, prio_rdata_i};
		else if (pal_hit)
			rd_data = pal_rdata_i;
		else if (md12_hit)
			rd_data = {1'b0, colour_codes_o.md2, 1'b0, colour_codes_o.md1};
		else if (md3_hit)
			rd_data = {2'b00, colour_codes_o.md0, 1'b0, colour_codes_o.md3};
		else if (pri_hit)
			rd_data = {3'b000, priority_ctrl_o};
		else if (hi_zero && (addr10 == ADDR_IN0))
			rd_data = {2'b10, inputs_i.shoot2, inputs_i.shoot, inputs_i.up,
				inputs_i.down, inputs_i.right, inputs_i.left};
		else if (hi_zero && (addr10 == ADDR_IN3))
			rd_data = {inputs_i.start2p, inputs_i.start1p, inputs_i.coina,
				inputs_i.coinb, 4'b0000};
		else if (hi_zero && (addr10 == ADDR_IN4))
			rd_data = {3'b111, inputs_i.service, 4'b0000};
		else if (hi_zero && (addr10 == ADDR_DSWA))
			rd_data = ~inputs_i.dip1;	// Switch on reads as 0
	end

	assign prdata_o = rd_data;

	// ========================================================================
	// Protocol checks
	// ========================================================================
	property p_enable_after_select;
		@(posedge V_BLANK) disable iff (!EXROM2)
		penable_i |-> $past(psel_i);
	endproperty
	a_enable_after_select: assert property (p_enable_after_select);

	property p_addr_stable_in_wait;
		@(posedge V_BLANK) disable iff (!EXROM2)
		(psel_i && penable_i && !pready_o) |=> $stable(paddr_i);
	endproperty
	a_addr_stable_in_wait: assert property (p_addr_stable_in_wait);

endmodule

`default_nettype wire

// ==== design/sj_priority_mixer.sv ====
// Priority table is undefined until written; control registers are sampled live each pixel
`default_nettype none

module sj_priority_mixer (
	input  wire logic                      V_BLANK,
	input  wire logic                      EXROM2,
	input  wire logic                      pix_ce_i,
	input  wire sj_pkg::sj_layer_pix_t     layer_pix_i,
	input  wire logic                      blank_i,
	input  wire sj_pkg::sj_colour_codes_t  colour_codes_i,
	input  wire logic [4:0]                priority_ctrl_i,
	input  wire sj_pkg::sj_ram_req_t       ram_req_i,
	output logic [3:0]                     prio_rdata_o,
	output sj_pkg::sj_pal_index_u          pal_index_o,
	output logic                           blank_o
);

	import sj_pkg::*;

	logic [3:0]    prio_tab [256];
	logic [7:0]    tab_addr;
	logic [3:0]    tab_entry;
	sj_layer_e     layer_sel;
	sj_layer_e     layer_q;		// Winning layer of stage 1
	sj_layer_pix_t pix_q;
	logic          blank_q;
	sj_pal_index_u pal_next;

	// ========================================================================
	// Stage 1: table lookup
	// ========================================================================
	assign tab_addr = {priority_ctrl_i[3:0], |layer_pix_i.sn3, |layer_pix_i.sn2,
		|layer_pix_i.sn1, |layer_pix_i.ob[2:0]};
	assign tab_entry = prio_tab[tab_addr];
	assign layer_sel = sj_layer_e'(priority_ctrl_i[4] ? tab_entry[3:2] : tab_entry[1:0]);

	// CPU port of the table
	always_ff @(posedge V_BLANK) begin
		if (ram_req_i.sel == RAM_PRIO) begin
			if (ram_req_i.we)
				prio_tab[ram_req_i.addr] <= ram_req_i.wdata[3:0];
			prio_rdata_o <= prio_tab[ram_req_i.addr];
		end
	end

	// ========================================================================
	// Stage 2: palette index
	// ========================================================================
	always_comb begin
		pal_next = '0;
		case (layer_q)
			LAYER_OBJ: begin
				pal_next.obj.md0 = colour_codes_i.md0;
				pal_next.obj.pix = pix_q.ob;	// Full 4 bits for sprites
			end
			LAYER_TM1: begin
				pal_next.tile.md  = colour_codes_i.md1;
				pal_next.tile.pix = pix_q.sn1;
			end
			LAYER_TM2: begin
				pal_next.tile.md  = colour_codes_i.md2;
				pal_next.tile.pix = pix_q.sn2;
			end
			default: begin
				pal_next.tile.md  = colour_codes_i.md3;
				pal_next.tile.pix = pix_q.sn3;
			end
		endcase
	end

	always_ff @(posedge V_BLANK) begin
		if (pix_ce_i) begin
			layer_q     <= layer_sel;
			pix_q       <= layer_pix_i;
			pal_index_o <= pal_next;
		end
	end

	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			blank_q <= 1'b0;
			blank_o <= 1'b0;
		end else if (pix_ce_i) begin
			blank_q <= blank_i;
			blank_o <= blank_q;		// Stays beside pal_index
		end
	end

	a_pix_known: assert property (@(posedge V_BLANK) disable iff (!EXROM2)
		pix_ce_i |-> !$isunknown(layer_pix_i));

endmodule

`default_nettype wire

// ==== design/sj_palette_out.sv ====
// Palette is undefined until written; odd byte writes only load the ninth-bit latch
`default_nettype none

module sj_palette_out (
	input  wire logic                   V_BLANK,
	input  wire logic                   EXROM2,
	input  wire logic                   pix_ce_i,
	input  wire sj_pkg::sj_pal_index_u  pal_index_i,
	input  wire logic                   blank_i,
	input  wire sj_pkg::sj_ram_req_t    ram_req_i,
	output logic [7:0]                  pal_rdata_o,
	output sj_pkg::sj_rgb_t             rgb_o
);

	import sj_pkg::*;

	logic [8:0] pal_ram [64];
	logic       hi_latch_q;		// Bit 8 for the next even write
	logic       pal_sel;
	logic [5:0] cpu_entry;
	logic [5:0] pal_addr;
	logic [8:0] pal_q;
	logic       blank_q;

	assign pal_sel   = (ram_req_i.sel == RAM_PAL);
	assign cpu_entry = ram_req_i.addr[6:1];
	assign pal_addr  = pal_index_i;	// Either view is the same 6-bit word

	// ========================================================================
	// CPU byte access
	// ========================================================================
	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2)
			hi_latch_q <= 1'b0;
		else if (pal_sel && ram_req_i.we && ram_req_i.addr[0])
			hi_latch_q <= ram_req_i.wdata[0];
	end

	always_ff @(posedge V_BLANK) begin
		if (pal_sel) begin
			if (ram_req_i.we && !ram_req_i.addr[0])
				pal_ram[cpu_entry] <= {hi_latch_q, ram_req_i.wdata};
			if (ram_req_i.addr[0])
				pal_rdata_o <= {7'b0000000, pal_ram[cpu_entry][8]};
			else
				pal_rdata_o <= pal_ram[cpu_entry][7:0];
		end
		if (pix_ce_i)
			pal_q <= pal_ram[pal_addr];		// Stage 3 lookup
	end

	// ========================================================================
	// Stage 4: inverted RGB with blanking
	// ========================================================================
	always_ff @(posedge V_BLANK or negedge EXROM2) begin
		if (!EXROM2) begin
			blank_q <= 1'b0;
			rgb_o   <= '0;
		end else if (pix_ce_i) begin
			blank_q <= blank_i;
			if (blank_q) begin
				rgb_o <= '0;
			end else begin
				rgb_o.red   <= ~pal_q[8:6];
				rgb_o.green <= ~pal_q[5:3];
				rgb_o.blue  <= ~pal_q[2:0];
			end
		end
	end

	a_blank_black: assert property (@(posedge V_BLANK) disable iff (!EXROM2)
		(pix_ce_i && $past(pix_ce_i && blank_i)) |=> (rgb_o == '0));

endmodule

`default_nettype wire

// ==== design/sj_pkg.sv ====
// Shared types and a 10-bit byte address map; sj_inputs_t expects active-high controls
`default_nettype none

package sj_pkg;

	// ========================================================================
	// Pixel side
	// ========================================================================
	typedef struct packed {
		logic [2:0] sn1;	// Tilemap 1 pixel
		logic [2:0] sn2;	// Tilemap 2 pixel
		logic [2:0] sn3;	// Tilemap 3 pixel
		logic [3:0] ob;		// Sprite pixel, bit 3 is extra colour
	} sj_layer_pix_t;

	typedef struct packed {
		logic [2:0] md1;
		logic [2:0] md2;
		logic [2:0] md3;
		logic [1:0] md0;	// Sprite colour code
	} sj_colour_codes_t;

	// A sprite index carries a 4-bit pixel, a tile index only 3
	typedef struct packed {
		logic [1:0] md0;
		logic [3:0] pix;
	} sj_pal_obj_t;

	typedef struct packed {
		logic [2:0] md;
		logic [2:0] pix;
	} sj_pal_tile_t;

	typedef union packed {
		sj_pal_obj_t  obj;
		sj_pal_tile_t tile;
	} sj_pal_index_u;

	typedef enum logic [1:0] {
		LAYER_OBJ = 2'd0,
		LAYER_TM1 = 2'd1,
		LAYER_TM2 = 2'd2,
		LAYER_TM3 = 2'd3
	} sj_layer_e;

	typedef struct packed {
		logic [2:0] red;
		logic [2:0] green;
		logic [2:0] blue;
	} sj_rgb_t;

	// ========================================================================
	// CPU side
	// ========================================================================
	typedef enum logic [2:0] {
		RAM_NONE = 3'b000,
		RAM_PRIO = 3'b001,	// Priority table
		RAM_PAL  = 3'b010	// Palette bytes
	} sj_ram_sel_e;

	typedef struct packed {
		logic        we;
		logic [7:0]  addr;
		logic [7:0]  wdata;
		sj_ram_sel_e sel;
	} sj_ram_req_t;

	typedef struct packed {
		logic       right;
		logic       left;
		logic       up;
		logic       down;
		logic       shoot;
		logic       shoot2;
		logic       start1p;
		logic       start2p;
		logic       coina;
		logic       coinb;
		logic       service;
		logic [7:0] dip1;
	} sj_inputs_t;

	localparam logic [9:0] ADDR_PRIO_BASE = 10'h000;	// 256 entries
	localparam logic [9:0] ADDR_PAL_BASE  = 10'h100;	// 128 bytes
	localparam logic [9:0] ADDR_MD12      = 10'h200;
	localparam logic [9:0] ADDR_MD3       = 10'h201;
	localparam logic [9:0] ADDR_PRIORITY  = 10'h202;
	localparam logic [9:0] ADDR_IN0       = 10'h208;
	localparam logic [9:0] ADDR_DSWA      = 10'h20A;
	localparam logic [9:0] ADDR_IN3       = 10'h20B;
	localparam logic [9:0] ADDR_IN4       = 10'h20C;

endpackage

`default_nettype wire
